//--- bench/chanlink_readout_chk.sv
`timescale 1ns/1ps

module chanlink_readout_chk (
	input logic        RCLK,
	input logic        RST_RESYNC,
	input logic        dvalid,
	input logic [15:0] dout,
	input logic        last_wrd
);

	logic last_fail = 1'b0;
	logic end_fail  = 1'b0;
	logic rst_fail  = 1'b0;
	logic fail_seen;

	assign fail_seen = last_fail | end_fail | rst_fail;  // Set once any assertion has failed

	// Final word flag rides only on a valid word
	last_with_valid: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		last_wrd |-> dvalid)
	else begin
		last_fail = 1'b1;
		$error("last_wrd high while dvalid is low");
	end

	end_word: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		last_wrd |-> (dout == chanlink_pkg::FRM_END))
	else begin
		end_fail = 1'b1;
		$error("final frame word is not the end marker");
	end

	quiet_in_reset: assert property (@(posedge RCLK) RST_RESYNC |-> !dvalid)
	else begin
		rst_fail = 1'b1;
		$error("dvalid set while reset is asserted");
	end

endmodule

//--- bench/chanlink_readout_tb.sv
`timescale 1ns/1ps

module chanlink_readout_tb;

	localparam int TIMEOUT_CYC = 2000;

	logic                       RCLK = 1'b0;
	logic                       RST_RESYNC;
	logic                       fifo_rst;
	logic [6:0]                 samp_cnt;
	logic                       sample_wr;
	chanlink_pkg::sample_word_t sample;
	logic                       l1a_wr;
	chanlink_pkg::l1a_rec_t     l1a;
	logic                       warn;
	logic                       evt_buf_amt;
	logic                       evt_buf_afl;
	logic                       dvalid;
	logic [15:0]                dout;
	logic                       last_wrd;

	chanlink_pkg::l1a_rec_t     rec_q[$];   // Written and not yet framed
	chanlink_pkg::sample_word_t samp_q[$];
	int                         depth_q[$];
	chanlink_pkg::l1a_rec_t     cur_rec;
	chanlink_pkg::sample_word_t cur_samps [chanlink_pkg::SAMP_CNT_MAX];
	int                         cur_n;
	int                         cur_depth;
	int                         word_idx    = 0;
	logic                       in_frame    = 1'b0;
	int                         frames_sent = 0;
	int                         frames_done = 0;
	logic                       exp_warn    = 1'b0;
	string                      test_name   = "reset";

	always #10 RCLK = ~RCLK;

	chanlink_readout chanlink_readout_inst (.*);

	bind chanlink_readout chanlink_readout_chk chanlink_readout_chk_inst (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC), .dvalid(dvalid), .dout(dout),
		.last_wrd(last_wrd));

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare(input string what, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act)
			abort_run($sformatf("error: test %s, %s: expected %h, actual %h",
				test_name, what, exp, act));
	endtask

	//////////////////////////////
	// Reference frame model
	//////////////////////////////

	function automatic logic [15:0] expect_word(
		input chanlink_pkg::l1a_rec_t     rec,
		input chanlink_pkg::sample_word_t samps [chanlink_pkg::SAMP_CNT_MAX],
		input int                         n,
		input int                         depth,
		input logic                       warn_bit,
		input int                         idx
	);
		logic [14:0] crc;
		logic        ser;
		int          i;
		crc = '0;
		if (idx < n) begin
			ser = rec.phase && (idx < chanlink_pkg::PHASE_WORDS);  // Phase on leading words only
			return {1'b0, ~samps[idx].ovrlp, ser, 1'b0, samps[idx].adc};
		end
		for (i = 0; i < n; i++)
			crc = chanlink_pkg::crc15_d13({1'b0, samps[i].adc}, crc);
		case (idx - n)
			0:       return {1'b0, crc};
			1:       return chanlink_pkg::FRM_HDR_A;
			2:       return {4'h7, rec.evt_num[5:0], 5'(depth), warn_bit};
			default: return chanlink_pkg::FRM_END;
		endcase
	endfunction

	// Collects each dvalid run and checks it word by word
	always @(negedge RCLK) begin
		int i;
		if (dvalid && !in_frame) begin
			if (rec_q.size() == 0 || depth_q.size() == 0 || samp_q.size() < int'(samp_cnt))
				abort_run("a frame came out with no complete event written for it");
			cur_rec   = rec_q.pop_front();
			cur_depth = depth_q.pop_front();
			cur_n     = int'(samp_cnt);
			for (i = 0; i < cur_n; i++)
				cur_samps[i] = samp_q.pop_front();
			in_frame = 1'b1;
			word_idx = 0;
		end
		if (dvalid) begin
			compare($sformatf("dout word %0d", word_idx),
				expect_word(cur_rec, cur_samps, cur_n, cur_depth, exp_warn, word_idx), dout);
			compare($sformatf("last_wrd at word %0d", word_idx),
				16'(word_idx == cur_n + 3), 16'(last_wrd));
			if (last_wrd) begin
				in_frame = 1'b0;
				frames_done++;
			end else
				word_idx++;
		end else if (in_frame)
			abort_run("dvalid dropped in the middle of a frame");
	end

	always @(negedge RCLK) begin
		if (chanlink_readout_inst.chanlink_readout_chk_inst.fail_seen)
			abort_run("an assertion on the output protocol failed");
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic start_test(input string name, input int n, input logic w);
		@(posedge RCLK);
		samp_cnt  <= 7'(n);
		warn      <= w;
		exp_warn  = w;
		test_name = name;
	endtask

	task automatic write_record(input int depth);
		logic [31:0]            r;
		chanlink_pkg::l1a_rec_t rec;
		r            = $urandom();
		rec.evt_num  = r[23:0];
		r            = $urandom();
		rec.phase    = r[12];
		rec.mtch_cnt = r[11:0];
		@(posedge RCLK);
		l1a_wr    <= 1'b1;
		l1a       <= rec;
		sample_wr <= 1'b0;
		rec_q.push_back(rec);
		depth_q.push_back(depth);
		frames_sent++;
	endtask

	task automatic write_sample();
		logic [31:0] r;
		r = $urandom();
		@(posedge RCLK);
		sample_wr <= 1'b1;
		sample    <= chanlink_pkg::sample_word_t'(r[17:0]);
		l1a_wr    <= 1'b0;
		samp_q.push_back(chanlink_pkg::sample_word_t'(r[17:0]));
	endtask

	task automatic bus_idle();
		@(posedge RCLK);
		sample_wr <= 1'b0;
		l1a_wr    <= 1'b0;
	endtask

	task automatic send_event(input int n);
		write_record(1);
		repeat (n) write_sample();
		bus_idle();
	endtask

	task automatic wait_frames();
		int cyc;
		cyc = 0;
		while (frames_done != frames_sent) begin
			@(posedge RCLK);
			cyc++;
			if (cyc > TIMEOUT_CYC)
				abort_run("timeout while waiting for the frames of the written events");
		end
	endtask

	initial begin
		void'($urandom(94));
		RST_RESYNC = 1'b1;
		fifo_rst   = 1'b0;
		samp_cnt   = 7'd8;
		sample_wr  = 1'b0;
		sample     = '0;
		l1a_wr     = 1'b0;
		l1a        = '0;
		warn       = 1'b0;
		repeat (5) @(posedge RCLK);
		RST_RESYNC <= 1'b0;
		@(negedge RCLK);
		compare("evt_buf_amt", 16'd1, 16'(evt_buf_amt));
		compare("evt_buf_afl", 16'd0, 16'(evt_buf_afl));
		compare("dvalid", 16'd0, 16'(dvalid));
		compare("last_wrd", 16'd0, 16'(last_wrd));
		compare("dout", 16'd0, dout);

		start_test("single_event", 8, 1'b0);
		send_event(8);
		wait_frames();

		start_test("phase_overlap", 10, 1'b0);
		repeat (4) begin
			send_event(10);
			wait_frames();
		end

		// Records queue up first and the depth field counts down
		start_test("queued_records", 8, 1'b0);
		write_record(3);
		write_record(2);
		write_record(1);
		repeat (24) write_sample();
		bus_idle();
		wait_frames();

		start_test("warn_crc", 96, 1'b1);
		repeat (3) begin
			send_event(96);
			wait_frames();
		end

		start_test("occupancy", 8, 1'b0);
		repeat (200) write_sample();
		bus_idle();
		@(negedge RCLK);
		compare("evt_buf_amt", 16'd0, 16'(evt_buf_amt));
		compare("evt_buf_afl", 16'd1, 16'(evt_buf_afl));
		repeat (20) @(posedge RCLK);  // Without a record no frame may start
		fifo_rst <= 1'b1;
		@(posedge RCLK);
		fifo_rst <= 1'b0;
		@(negedge RCLK);
		samp_q.delete();
		compare("evt_buf_amt", 16'd1, 16'(evt_buf_amt));
		compare("evt_buf_afl", 16'd0, 16'(evt_buf_afl));

		if (chanlink_readout_inst.chanlink_readout_chk_inst.fail_seen)
			abort_run("an assertion on the output protocol failed");
		else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

//--- chanlink.f
hw/chanlink_pkg.sv
hw/sync_fifo.sv
hw/frame_builder.sv
hw/chanlink_readout.sv
bench/chanlink_readout_chk.sv
bench/chanlink_readout_tb.sv

//--- hw/chanlink_pkg.sv
package chanlink_pkg;

	//////////////////////////////
	// Payload records
	//////////////////////////////

	typedef struct packed {
		logic        movlp;     // Multi-overlap flag
		logic        ovrlp;
		logic [3:0]  ocnt;      // Overlap count
		logic [11:0] adc;
	} sample_word_t;

	typedef struct packed {
		logic        phase;
		logic [11:0] mtch_cnt;  // Match count
		logic [23:0] evt_num;
	} l1a_rec_t;

	//////////////////////////////
	// Buffer sizes and frame constants
	//////////////////////////////

	localparam int EVT_DEPTH      = 256;
	localparam int L1A_DEPTH      = 32;
	localparam int EVT_CNT_W      = $clog2(EVT_DEPTH + 1);
	localparam int L1A_CNT_W      = $clog2(L1A_DEPTH + 1);
	localparam int EVT_AFULL_LVL  = 192;
	localparam int EVT_AEMPTY_LVL = 16;
	localparam int SAMP_CNT_MAX   = 96;
	localparam int PHASE_WORDS    = 6;  // Leading words carrying the phase bit

	localparam logic [15:0] FRM_HDR_A = 16'h700C;
	localparam logic [15:0] FRM_END   = 16'h7FFF;

	// One parallel step of the CRC-15 over 13 data bits
	function automatic logic [14:0] crc15_d13(input logic [12:0] d, input logic [14:0] c);
		logic [14:0] n;
		n[0]  = d[0] ^ c[2];
		n[1]  = d[0] ^ d[1] ^ c[2] ^ c[3];
		n[2]  = d[1] ^ d[2] ^ c[3] ^ c[4];
		n[3]  = d[2] ^ d[3] ^ c[4] ^ c[5];
		n[4]  = d[3] ^ d[4] ^ c[5] ^ c[6];
		n[5]  = d[4] ^ d[5] ^ c[6] ^ c[7];
		n[6]  = d[5] ^ d[6] ^ c[7] ^ c[8];
		n[7]  = d[6] ^ d[7] ^ c[8] ^ c[9];
		n[8]  = d[7] ^ d[8] ^ c[9] ^ c[10];
		n[9]  = d[8] ^ d[9] ^ c[10] ^ c[11];
		n[10] = d[9] ^ d[10] ^ c[11] ^ c[12];
		n[11] = d[10] ^ d[11] ^ c[12] ^ c[13];
		n[12] = d[11] ^ d[12] ^ c[13] ^ c[14];
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];  // Pure shift
		return n;
	endfunction

endpackage

//--- hw/chanlink_readout.sv
`timescale 1ns/1ps

module chanlink_readout (
	input  logic                       RCLK,
	input  logic                       RST_RESYNC,
	input  logic                       fifo_rst,
	input  logic [6:0]                 samp_cnt,
	input  logic                       sample_wr,
	input  chanlink_pkg::sample_word_t sample,
	input  logic                       l1a_wr,
	input  chanlink_pkg::l1a_rec_t     l1a,
	input  logic                       warn,
	output logic                       evt_buf_amt,
	output logic                       evt_buf_afl,
	output logic                       dvalid,
	output logic [15:0]                dout,
	output logic                       last_wrd
);

	chanlink_pkg::sample_word_t         evt_data;
	chanlink_pkg::l1a_rec_t             l1a_data;
	logic [chanlink_pkg::EVT_CNT_W-1:0] evt_count;
	logic [chanlink_pkg::L1A_CNT_W-1:0] l1a_count;
	logic                               evt_rd;
	logic                               l1a_rd;
	logic                               l1a_empty;

	// Occupancy thresholds of the event buffer
	assign evt_buf_amt = evt_count <= (chanlink_pkg::EVT_CNT_W)'(chanlink_pkg::EVT_AEMPTY_LVL);
	assign evt_buf_afl = evt_count >= (chanlink_pkg::EVT_CNT_W)'(chanlink_pkg::EVT_AFULL_LVL);

	//////////////////////////////
	// Buffers side by side
	//////////////////////////////

	sync_fifo #(
		.payload_t (chanlink_pkg::sample_word_t),
		.DEPTH     (chanlink_pkg::EVT_DEPTH)
	) evt_buf (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.clr        (fifo_rst),
		.wr         (sample_wr),
		.wr_data    (sample),
		.rd         (evt_rd),
		.rd_data    (evt_data),
		.count      (evt_count),
		.full       (),
		.empty      ()
	);

	sync_fifo #(
		.payload_t (chanlink_pkg::l1a_rec_t),
		.DEPTH     (chanlink_pkg::L1A_DEPTH)
	) l1a_buf (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.clr        (fifo_rst),
		.wr         (l1a_wr),
		.wr_data    (l1a),
		.rd         (l1a_rd),
		.rd_data    (l1a_data),
		.count      (l1a_count),
		.full       (),
		.empty      (l1a_empty)
	);

	frame_builder frame_builder_inst (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.samp_cnt   (samp_cnt),
		.warn       (warn),
		.evt_rd     (evt_rd),
		.evt_data   (evt_data),
		.evt_count  (evt_count),
		.l1a_rd     (l1a_rd),
		.l1a_data   (l1a_data),
		.l1a_empty  (l1a_empty),
		.l1a_count  (l1a_count),
		.dvalid     (dvalid),
		.dout       (dout),
		.last_wrd   (last_wrd)
	);

endmodule

//--- hw/frame_builder.sv
`timescale 1ns/1ps

module frame_builder (
	input  logic                               RCLK,
	input  logic                               RST_RESYNC,
	input  logic [6:0]                         samp_cnt,
	input  logic                               warn,
	output logic                               evt_rd,
	input  chanlink_pkg::sample_word_t         evt_data,
	input  logic [chanlink_pkg::EVT_CNT_W-1:0] evt_count,
	output logic                               l1a_rd,
	input  chanlink_pkg::l1a_rec_t             l1a_data,
	input  logic                               l1a_empty,
	input  logic [chanlink_pkg::L1A_CNT_W-1:0] l1a_count,
	output logic                               dvalid,
	output logic [15:0]                        dout,
	output logic                               last_wrd
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_L1A,
		S_DATA,
		S_CRC,
		S_TRAIL,
		S_END
	} frm_state_t;

	frm_state_t  state;
	frm_state_t  st_b;       // Sequencer slot, one cycle late
	logic [6:0]  seq;
	logic [6:0]  seq_b;
	logic        samp_ok;
	logic        start;
	logic        serial;
	logic        rec_phase;
	logic [5:0]  rec_evt;
	logic [4:0]  depth;
	logic [14:0] crc;

	assign samp_ok = (samp_cnt != 7'd0) && (samp_cnt <= 7'(chanlink_pkg::SAMP_CNT_MAX));
	assign start   = samp_ok && !l1a_empty &&
		(evt_count >= (chanlink_pkg::EVT_CNT_W)'(samp_cnt));

	// Pops go out straight from the state
	assign l1a_rd = (state == S_L1A);
	assign evt_rd = (state == S_DATA);

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state <= S_IDLE;
			seq   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					seq <= '0;
					if (start)
						state <= S_L1A;
				end
				S_L1A: state <= S_DATA;
				S_DATA: begin
					if (seq == samp_cnt - 7'd1) begin
						seq   <= '0;
						state <= S_CRC;
					end else
						seq <= seq + 7'd1;
				end
				S_CRC: state <= S_TRAIL;
				S_TRAIL: begin                 // Marker word, then info word
					if (seq == 7'd1) begin
						seq   <= '0;
						state <= S_END;
					end else
						seq <= seq + 7'd1;
				end
				S_END:   state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// L1A occupancy at event start, this event included
	always_ff @(posedge RCLK) begin
		if (state == S_IDLE && start)
			depth <= (l1a_count > (chanlink_pkg::L1A_CNT_W)'(31)) ? 5'd31 : l1a_count[4:0];
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			st_b  <= S_IDLE;
			seq_b <= '0;
		end else begin
			st_b  <= state;
			seq_b <= seq;
		end
	end

	//////////////////////////////
	// Word formation
	//////////////////////////////

	// Record arrives the cycle after its pop, CRC restarts with it
	always_ff @(posedge RCLK) begin
		if (st_b == S_L1A) begin
			rec_phase <= l1a_data.phase;
			rec_evt   <= l1a_data.evt_num[5:0];
			crc       <= '0;
		end else if (st_b == S_DATA)
			crc <= chanlink_pkg::crc15_d13({1'b0, evt_data.adc}, crc);
	end

	assign serial = rec_phase && (seq_b < 7'(chanlink_pkg::PHASE_WORDS));

	// Output registers, first dvalid three cycles after the record pop
	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			dvalid   <= 1'b0;
			last_wrd <= 1'b0;
			dout     <= '0;
		end else begin
			dvalid   <= 1'b1;
			last_wrd <= 1'b0;
			case (st_b)
				S_DATA:  dout <= {1'b0, ~evt_data.ovrlp, serial, 1'b0, evt_data.adc};
				S_CRC:   dout <= {1'b0, crc};
				S_TRAIL: dout <= (seq_b == 7'd0) ? chanlink_pkg::FRM_HDR_A :
					{4'h7, rec_evt, depth, warn};  // warn taken live here
				S_END: begin
					dout     <= chanlink_pkg::FRM_END;
					last_wrd <= 1'b1;
				end
				default: begin
					dvalid <= 1'b0;
					dout   <= '0;
				end
			endcase
		end
	end

endmodule

//--- hw/sync_fifo.sv
`timescale 1ns/1ps

// Single-clock FIFO, DEPTH must be a power of two so the pointers wrap
module sync_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 16
) (
	input  logic                       RCLK,
	input  logic                       RST_RESYNC,
	input  logic                       clr,
	input  logic                       wr,
	input  payload_t                   wr_data,
	input  logic                       rd,
	output payload_t                   rd_data,
	output logic [$clog2(DEPTH+1)-1:0] count,
	output logic                       full,
	output logic                       empty
);

	payload_t                 mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic                     do_wr;
	logic                     do_rd;

	assign full  = (count == ($clog2(DEPTH+1))'(DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr & ~full;   // Push into a full buffer is lost
	assign do_rd = rd & ~empty;

	//////////////////////////////
	// Pointers and occupancy
	//////////////////////////////

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

	// Storage, read word lands one cycle after rd
	always_ff @(posedge RCLK) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
		if (do_rd)
			rd_data <= mem[rd_ptr];
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the readout testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
MDIR=obj_dir

if ! verilator --binary --timing --assert --top-module chanlink_readout_tb \
	-f chanlink.f --Mdir "$MDIR" -o chanlink_sim; then
	echo "Verilator build failed"
	exit 1
fi

"./$MDIR/chanlink_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
echo "Simulation finished cleanly"
exit 0
